// File: db_gpio_pkg.sv
// GPIO package for the daughterboard GPIO block
// Line count per connector and the trace mapping tables of both slots
// Both tables share the same internal bit order

`default_nettype none

package db_gpio_pkg;

  // GPIO lines per daughterboard connector
  localparam int NUM_GPIO = 20;

  // Width of one entry in a mapping table
  localparam int MAP_IDX_W = 5;

  // One connector worth of GPIO lines
  typedef logic [NUM_GPIO-1:0] gpio_t;

  // Slot 0 mapping
  // Entry i holds the trace index carrying internal bit i
  // Listed from internal bit 19 down to internal bit 0
  localparam logic [MAP_IDX_W*NUM_GPIO-1:0] PORT0_MAPPING = {
    5'd19, 5'd17, 5'd0,  5'd14,
    5'd15, 5'd10, 5'd4,  5'd5,
    5'd16, 5'd18, 5'd8,  5'd6,
    5'd1,  5'd9,  5'd2,  5'd3,
    5'd11, 5'd7,  5'd13, 5'd12
  };

  // Slot 1 mapping
  // Traces on this connector are routed differently on the motherboard
  localparam logic [MAP_IDX_W*NUM_GPIO-1:0] PORT1_MAPPING = {
    5'd10, 5'd6,  5'd7,  5'd2,
    5'd3,  5'd0,  5'd1,  5'd4,
    5'd8,  5'd9,  5'd11, 5'd5,
    5'd13, 5'd12, 5'd15, 5'd14,
    5'd19, 5'd18, 5'd17, 5'd16
  };

endpackage : db_gpio_pkg

`default_nettype wire

// File: db_gpio_regs_pkg.sv
// Register map package for the daughterboard GPIO block
// Control port widths, slot select bit and the per-slot register offsets

`default_nettype none

package db_gpio_regs_pkg;

  // Control port bus widths
  localparam int CTRL_ADDR_W = 8;
  localparam int CTRL_DATA_W = 32;

  // Address bit choosing slot 1 when set
  localparam int SLOT_SEL_BIT = 4;

  // Low address bits decoded inside one slot
  localparam int REG_OFFSET_W = 4;

  // Per-slot register offsets
  // Offsets 4 to 15 are unmapped and read as zero
  typedef enum logic [REG_OFFSET_W-1:0] {
    // Output levels
    REG_GPIO_OUT     = 4'd0,
    // Output enables
    REG_GPIO_OUT_EN  = 4'd1,
    // Synchronized input levels, read only
    REG_GPIO_IN      = 4'd2,
    // Sticky change flags, write one to clear
    REG_GPIO_CHANGED = 4'd3
  } reg_offset_t;

endpackage : db_gpio_regs_pkg

`default_nettype wire

// File: ctrlport_if.sv
// Control port interface
// One request path and one response path between a master and a slave

`timescale 1ns/1ps
`default_nettype none

interface ctrlport_if;
  import db_gpio_regs_pkg::*;

  // Request side
  logic                   req_wr;
  logic                   req_rd;
  logic [CTRL_ADDR_W-1:0] req_addr;
  logic [CTRL_DATA_W-1:0] req_data;

  // Response side
  logic                   resp_ack;
  logic [CTRL_DATA_W-1:0] resp_data;

  // Issues requests and collects responses
  modport master (
    output req_wr, req_rd, req_addr, req_data,
    input  resp_ack, resp_data
  );

  // Answers requests
  modport slave (
    input  req_wr, req_rd, req_addr, req_data,
    output resp_ack, resp_data
  );

endinterface : ctrlport_if

`default_nettype wire

// File: db_gpio_reordering.sv
// Daughterboard GPIO reordering
// Maps the common internal bit order onto the connector traces of each slot
// so one daughterboard CPLD image works on both connectors
// Purely combinational

`timescale 1ns/1ps
`default_nettype none

module db_gpio_reordering (
  // Internal order, slot 0
  output wire db_gpio_pkg::gpio_t db0_gpio_in_int,
  input  db_gpio_pkg::gpio_t      db0_gpio_out_int,
  input  db_gpio_pkg::gpio_t      db0_gpio_out_en_int,
  // Internal order, slot 1
  output wire db_gpio_pkg::gpio_t db1_gpio_in_int,
  input  db_gpio_pkg::gpio_t      db1_gpio_out_int,
  input  db_gpio_pkg::gpio_t      db1_gpio_out_en_int,
  // Trace order, slot 0
  input  db_gpio_pkg::gpio_t      db0_gpio_in_ext,
  output wire db_gpio_pkg::gpio_t db0_gpio_out_ext,
  output wire db_gpio_pkg::gpio_t db0_gpio_out_en_ext,
  // Trace order, slot 1
  input  db_gpio_pkg::gpio_t      db1_gpio_in_ext,
  output wire db_gpio_pkg::gpio_t db1_gpio_out_ext,
  output wire db_gpio_pkg::gpio_t db1_gpio_out_en_ext
);
  import db_gpio_pkg::*;

  // One loop iteration per internal bit
  for (genvar i = 0; i < NUM_GPIO; i++) begin : g_reorder
    // Trace carrying internal bit i on each connector
    localparam int TRACE0 = int'(PORT0_MAPPING[i*MAP_IDX_W +: MAP_IDX_W]);
    localparam int TRACE1 = int'(PORT1_MAPPING[i*MAP_IDX_W +: MAP_IDX_W]);

    // Inputs come back from the trace to the internal bit
    assign db0_gpio_in_int[i] = db0_gpio_in_ext[TRACE0];
    assign db1_gpio_in_int[i] = db1_gpio_in_ext[TRACE1];

    // Output levels go out on the mapped trace
    assign db0_gpio_out_ext[TRACE0] = db0_gpio_out_int[i];
    assign db1_gpio_out_ext[TRACE1] = db1_gpio_out_int[i];

    // Output enables follow the same trace as their level
    assign db0_gpio_out_en_ext[TRACE0] = db0_gpio_out_en_int[i];
    assign db1_gpio_out_en_ext[TRACE1] = db1_gpio_out_en_int[i];
  end

endmodule : db_gpio_reordering

`default_nettype wire

// File: db_gpio_input_sync.sv
// GPIO input synchronizer for one slot
// Two flop synchronizer plus sticky per-bit change flags
// Flags are cleared by a masked write-one-to-clear pulse

`timescale 1ns/1ps
`default_nettype none

module db_gpio_input_sync (
  input  logic               ctrlport_clk,
  input  logic               rst_n,
  input  db_gpio_pkg::gpio_t gpio_async,
  input  db_gpio_pkg::gpio_t clear_mask,
  input  logic               clear,
  output db_gpio_pkg::gpio_t gpio_sync,
  output db_gpio_pkg::gpio_t changed
);
  import db_gpio_pkg::*;

  // First synchronizer stage, may go metastable
  gpio_t sync_meta;
  // Previous synchronized value for edge detection
  gpio_t sync_prev;
  // Bits that moved since the last cycle
  gpio_t diff;
  // Flags removed by the current clear pulse
  gpio_t clr_bits;

  assign diff     = gpio_sync ^ sync_prev;
  assign clr_bits = clear ? clear_mask : '0;

  always_ff @(posedge ctrlport_clk) begin
    if (!rst_n) begin
      sync_meta <= '0;
      gpio_sync <= '0;
      sync_prev <= '0;
      changed   <= '0;
    end else begin
      sync_meta <= gpio_async;
      gpio_sync <= sync_meta;
      sync_prev <= gpio_sync;
      // New change in the same cycle beats the clear
      changed   <= (changed & ~clr_bits) | diff;
    end
  end

endmodule : db_gpio_input_sync

`default_nettype wire

// File: db_gpio_regs.sv
// GPIO register block for one daughterboard slot
// Holds output levels and enables, reports synchronized inputs
// and sticky change flags over the control port
// Every request is answered with one registered ack a cycle later

`timescale 1ns/1ps
`default_nettype none

module db_gpio_regs (
  input  logic               ctrlport_clk,
  input  logic               rst_n,
  ctrlport_if.slave          bus,
  input  db_gpio_pkg::gpio_t gpio_in,
  output db_gpio_pkg::gpio_t gpio_out,
  output db_gpio_pkg::gpio_t gpio_out_en
);
  import db_gpio_pkg::*;
  import db_gpio_regs_pkg::*;

  // Zero padding above the GPIO bits in a data word
  localparam int PAD_W = CTRL_DATA_W - NUM_GPIO;

  // Decoded register offset
  reg_offset_t offset;

  // Synchronizer outputs
  gpio_t gpio_sync;
  gpio_t gpio_changed;

  // Change flag clear strobe and its mask
  logic  chg_clear;
  gpio_t chg_clear_mask;

  // Read data before the response register
  logic [CTRL_DATA_W-1:0] rd_data;

  // Only the low address bits matter inside a slot
  assign offset = reg_offset_t'(bus.req_addr[REG_OFFSET_W-1:0]);

  // Write one to clear on the change register
  assign chg_clear      = bus.req_wr && (offset == REG_GPIO_CHANGED);
  assign chg_clear_mask = bus.req_data[NUM_GPIO-1:0];

  db_gpio_input_sync input_sync_inst (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .gpio_async   (gpio_in),
    .clear_mask   (chg_clear_mask),
    .clear        (chg_clear),
    .gpio_sync    (gpio_sync),
    .changed      (gpio_changed)
  );

  // Output registers
  always_ff @(posedge ctrlport_clk) begin
    if (!rst_n) begin
      gpio_out    <= '0;
      gpio_out_en <= '0;
    end else if (bus.req_wr) begin
      case (offset)
        REG_GPIO_OUT:    gpio_out    <= bus.req_data[NUM_GPIO-1:0];
        REG_GPIO_OUT_EN: gpio_out_en <= bus.req_data[NUM_GPIO-1:0];
        // Read only and unmapped offsets drop the write
        default: ;
      endcase
    end
  end

  // Read mux, zero extended to the bus width
  always_comb begin
    case (offset)
      REG_GPIO_OUT:     rd_data = {{PAD_W{1'b0}}, gpio_out};
      REG_GPIO_OUT_EN:  rd_data = {{PAD_W{1'b0}}, gpio_out_en};
      REG_GPIO_IN:      rd_data = {{PAD_W{1'b0}}, gpio_sync};
      REG_GPIO_CHANGED: rd_data = {{PAD_W{1'b0}}, gpio_changed};
      default:          rd_data = '0;
    endcase
  end

  // Response register
  // Ack for reads and writes alike, data only for reads
  always_ff @(posedge ctrlport_clk) begin
    if (!rst_n) begin
      bus.resp_ack  <= 1'b0;
      bus.resp_data <= '0;
    end else begin
      bus.resp_ack  <= bus.req_wr | bus.req_rd;
      bus.resp_data <= bus.req_rd ? rd_data : '0;
    end
  end

endmodule : db_gpio_regs

`default_nettype wire

// File: db_gpio_ctrlport_split.sv
// Control port splitter for the two daughterboard slots
// Steers each request to one slot register block by the slot select bit
// and merges the two responses back onto the upstream port
// Combinational in both directions

`timescale 1ns/1ps
`default_nettype none

module db_gpio_ctrlport_split (
  // Upstream control port
  input  logic                                     s_req_wr,
  input  logic                                     s_req_rd,
  input  logic [db_gpio_regs_pkg::CTRL_ADDR_W-1:0] s_req_addr,
  input  logic [db_gpio_regs_pkg::CTRL_DATA_W-1:0] s_req_data,
  output logic                                     s_resp_ack,
  output logic [db_gpio_regs_pkg::CTRL_DATA_W-1:0] s_resp_data,
  // Per slot control ports
  ctrlport_if.master                               slot0_bus,
  ctrlport_if.master                               slot1_bus
);
  import db_gpio_regs_pkg::*;

  // High selects slot 1
  logic slot_sel;

  assign slot_sel = s_req_addr[SLOT_SEL_BIT];

  // Strobes reach only the selected slot
  assign slot0_bus.req_wr = s_req_wr & ~slot_sel;
  assign slot0_bus.req_rd = s_req_rd & ~slot_sel;
  assign slot1_bus.req_wr = s_req_wr &  slot_sel;
  assign slot1_bus.req_rd = s_req_rd &  slot_sel;

  // Address and data fan out to both slots
  // Offsets are decoded inside each register block
  assign slot0_bus.req_addr = s_req_addr;
  assign slot0_bus.req_data = s_req_data;
  assign slot1_bus.req_addr = s_req_addr;
  assign slot1_bus.req_data = s_req_data;

  // At most one request in flight so only one slot acks at a time
  assign s_resp_ack = slot0_bus.resp_ack | slot1_bus.resp_ack;

  // Data from whichever slot answered
  assign s_resp_data = slot1_bus.resp_ack ? slot1_bus.resp_data
                                          : slot0_bus.resp_data;

endmodule : db_gpio_ctrlport_split

`default_nettype wire

// File: db_gpio_top.sv
// Daughterboard GPIO top level
// Control port registers for the GPIO lines of two daughterboard slots
// Splitter, one register block per slot and the trace reordering layer
// All logic runs on the control port clock

`timescale 1ns/1ps
`default_nettype none

module db_gpio_top (
  input  logic                                     ctrlport_clk,
  input  logic                                     rst_n,
  // Control port
  input  logic                                     s_req_wr,
  input  logic                                     s_req_rd,
  input  logic [db_gpio_regs_pkg::CTRL_ADDR_W-1:0] s_req_addr,
  input  logic [db_gpio_regs_pkg::CTRL_DATA_W-1:0] s_req_data,
  output logic                                     s_resp_ack,
  output logic [db_gpio_regs_pkg::CTRL_DATA_W-1:0] s_resp_data,
  // Slot 0 connector, trace order
  input  db_gpio_pkg::gpio_t                       db0_gpio_in_ext,
  output db_gpio_pkg::gpio_t                       db0_gpio_out_ext,
  output db_gpio_pkg::gpio_t                       db0_gpio_out_en_ext,
  // Slot 1 connector, trace order
  input  db_gpio_pkg::gpio_t                       db1_gpio_in_ext,
  output db_gpio_pkg::gpio_t                       db1_gpio_out_ext,
  output db_gpio_pkg::gpio_t                       db1_gpio_out_en_ext
);
  import db_gpio_pkg::*;

  // Per slot control ports
  ctrlport_if slot0_bus ();
  ctrlport_if slot1_bus ();

  // Internal order GPIO vectors
  gpio_t db0_gpio_in_int;
  gpio_t db0_gpio_out_int;
  gpio_t db0_gpio_out_en_int;
  gpio_t db1_gpio_in_int;
  gpio_t db1_gpio_out_int;
  gpio_t db1_gpio_out_en_int;

  db_gpio_ctrlport_split ctrlport_split_inst (
    .s_req_wr    (s_req_wr),
    .s_req_rd    (s_req_rd),
    .s_req_addr  (s_req_addr),
    .s_req_data  (s_req_data),
    .s_resp_ack  (s_resp_ack),
    .s_resp_data (s_resp_data),
    .slot0_bus   (slot0_bus.master),
    .slot1_bus   (slot1_bus.master)
  );

  // Slot 0 registers
  db_gpio_regs slot0_regs (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .bus          (slot0_bus.slave),
    .gpio_in      (db0_gpio_in_int),
    .gpio_out     (db0_gpio_out_int),
    .gpio_out_en  (db0_gpio_out_en_int)
  );

  // Slot 1 registers
  db_gpio_regs slot1_regs (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .bus          (slot1_bus.slave),
    .gpio_in      (db1_gpio_in_int),
    .gpio_out     (db1_gpio_out_int),
    .gpio_out_en  (db1_gpio_out_en_int)
  );

  // Internal order to connector trace order
  db_gpio_reordering reordering_inst (
    .db0_gpio_in_int     (db0_gpio_in_int),
    .db0_gpio_out_int    (db0_gpio_out_int),
    .db0_gpio_out_en_int (db0_gpio_out_en_int),
    .db1_gpio_in_int     (db1_gpio_in_int),
    .db1_gpio_out_int    (db1_gpio_out_int),
    .db1_gpio_out_en_int (db1_gpio_out_en_int),
    .db0_gpio_in_ext     (db0_gpio_in_ext),
    .db0_gpio_out_ext    (db0_gpio_out_ext),
    .db0_gpio_out_en_ext (db0_gpio_out_en_ext),
    .db1_gpio_in_ext     (db1_gpio_in_ext),
    .db1_gpio_out_ext    (db1_gpio_out_ext),
    .db1_gpio_out_en_ext (db1_gpio_out_en_ext)
  );

endmodule : db_gpio_top

`default_nettype wire

// File: tb_db_gpio.sv
// Testbench for the daughterboard GPIO block
// Walks a table of control port writes, reads and input changes
// and checks read data and connector pins against a register model

`timescale 1ns/1ps
`default_nettype none

module tb_db_gpio;
  import db_gpio_pkg::*;
  import db_gpio_regs_pkg::*;

  typedef enum {OP_WRITE, OP_READ, OP_SET_IN} op_t;

  // One table row and the pin state the model expects after it
  typedef struct {
    op_t         op;
    int          slot;
    int          offset;
    logic [31:0] data;
    logic [31:0] exp_data;
    gpio_t       exp_out0;
    gpio_t       exp_en0;
    gpio_t       exp_out1;
    gpio_t       exp_en1;
  } entry_t;

  logic                   ctrlport_clk;
  logic                   rst_n;
  logic                   s_req_wr;
  logic                   s_req_rd;
  logic [CTRL_ADDR_W-1:0] s_req_addr;
  logic [CTRL_DATA_W-1:0] s_req_data;
  logic                   s_resp_ack;
  logic [CTRL_DATA_W-1:0] s_resp_data;
  gpio_t                  db0_gpio_in_ext;
  gpio_t                  db0_gpio_out_ext;
  gpio_t                  db0_gpio_out_en_ext;
  gpio_t                  db1_gpio_in_ext;
  gpio_t                  db1_gpio_out_ext;
  gpio_t                  db1_gpio_out_en_ext;

  entry_t      tbl [$];
  logic        table_built;
  logic [31:0] lfsr_state;
  int          entry_errors;
  int          errors;
  int          bad_entries;

  // Register model per slot
  // Inputs are kept in trace order
  gpio_t m_out [2];
  gpio_t m_en [2];
  gpio_t m_ext [2];
  gpio_t m_changed [2];

  db_gpio_top db_gpio_top_inst (.*);

  initial begin
    ctrlport_clk = 1'b0;
    forever #5 ctrlport_clk = ~ctrlport_clk;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_built === 1'b1);
    repeat (16 + 200 * tbl.size()) @(posedge ctrlport_clk);
    $display("Timeout, the table did not complete in %0d cycles", 16 + 200 * tbl.size());
    $display("Test failed");
    $finish;
  end

  // Right-shift Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_gpio(output gpio_t w);
    for (int i = 0; i < NUM_GPIO; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[i] = lfsr_state[0];
    end
  endtask

  // Trace that carries internal bit b on a slot
  function automatic int trace_of(int slot, int b);
    if (slot == 0)
      return int'(PORT0_MAPPING[b*MAP_IDX_W +: MAP_IDX_W]);
    return int'(PORT1_MAPPING[b*MAP_IDX_W +: MAP_IDX_W]);
  endfunction

  function automatic gpio_t map_to_traces(int slot, gpio_t int_vec);
    gpio_t ext;
    ext = '0;
    for (int i = 0; i < NUM_GPIO; i++)
      ext[trace_of(slot, i)] = int_vec[i];
    return ext;
  endfunction

  function automatic gpio_t map_to_internal(int slot, gpio_t ext);
    gpio_t int_vec;
    for (int i = 0; i < NUM_GPIO; i++)
      int_vec[i] = ext[trace_of(slot, i)];
    return int_vec;
  endfunction

  task automatic push_entry(op_t op, int slot, int offset, logic [31:0] data,
                            logic [31:0] exp_data);
    entry_t e;
    e.op       = op;
    e.slot     = slot;
    e.offset   = offset;
    e.data     = data;
    e.exp_data = exp_data;
    e.exp_out0 = map_to_traces(0, m_out[0]);
    e.exp_en0  = map_to_traces(0, m_en[0]);
    e.exp_out1 = map_to_traces(1, m_out[1]);
    e.exp_en1  = map_to_traces(1, m_en[1]);
    tbl.push_back(e);
  endtask

  task automatic write_entry(int slot, int offset, logic [31:0] data);
    case (offset)
      int'(REG_GPIO_OUT):     m_out[slot] = data[NUM_GPIO-1:0];
      int'(REG_GPIO_OUT_EN):  m_en[slot]  = data[NUM_GPIO-1:0];
      int'(REG_GPIO_CHANGED): m_changed[slot] &= ~data[NUM_GPIO-1:0];
      // Input register and unmapped offsets keep their state
      default: ;
    endcase
    push_entry(OP_WRITE, slot, offset, data, 32'h0);
  endtask

  task automatic read_entry(int slot, int offset);
    logic [31:0] exp_data;
    case (offset)
      int'(REG_GPIO_OUT):     exp_data = 32'(m_out[slot]);
      int'(REG_GPIO_OUT_EN):  exp_data = 32'(m_en[slot]);
      int'(REG_GPIO_IN):      exp_data = 32'(map_to_internal(slot, m_ext[slot]));
      int'(REG_GPIO_CHANGED): exp_data = 32'(m_changed[slot]);
      default:                exp_data = 32'h0;
    endcase
    push_entry(OP_READ, slot, offset, 32'h0, exp_data);
  endtask

  task automatic input_entry(int slot, gpio_t ext);
    // Each internal bit that moves leaves a sticky flag
    m_changed[slot] |= map_to_internal(slot, m_ext[slot]) ^ map_to_internal(slot, ext);
    m_ext[slot] = ext;
    push_entry(OP_SET_IN, slot, 0, 32'(ext), 32'h0);
  endtask

  task automatic build_table();
    gpio_t w;
    gpio_t one_hot;
    // All registers read zero out of reset
    for (int s = 0; s < 2; s++)
      for (int off = 0; off < 4; off++)
        read_entry(s, off);
    // One-hot walk on levels and enables followed by random words
    for (int s = 0; s < 2; s++) begin
      for (int off = 0; off < 2; off++) begin
        for (int b = 0; b < NUM_GPIO; b++)
          write_entry(s, off, 32'h1 << b);
        repeat (4) begin
          random_gpio(w);
          write_entry(s, off, 32'(w));
          read_entry(s, off);
        end
      end
    end
    // Trace order inputs come back in internal order
    for (int s = 0; s < 2; s++) begin
      for (int b = 0; b < NUM_GPIO; b++) begin
        one_hot    = '0;
        one_hot[b] = 1'b1;
        input_entry(s, one_hot);
        read_entry(s, int'(REG_GPIO_IN));
      end
      repeat (4) begin
        random_gpio(w);
        input_entry(s, w);
        read_entry(s, int'(REG_GPIO_IN));
      end
    end
    // Change flags stay set after the input settles
    // A masked clear then drops only the masked bits
    for (int s = 0; s < 2; s++) begin
      write_entry(s, int'(REG_GPIO_CHANGED), 32'hffff_ffff);
      read_entry(s, int'(REG_GPIO_CHANGED));
      random_gpio(w);
      input_entry(s, w);
      read_entry(s, int'(REG_GPIO_CHANGED));
      input_entry(s, w);
      read_entry(s, int'(REG_GPIO_CHANGED));
      random_gpio(w);
      write_entry(s, int'(REG_GPIO_CHANGED), 32'(w));
      read_entry(s, int'(REG_GPIO_CHANGED));
    end
    // Read only and unmapped offsets
    for (int s = 0; s < 2; s++) begin
      for (int off = 2; off < 16; off++) begin
        if (off != int'(REG_GPIO_CHANGED)) begin
          random_gpio(w);
          write_entry(s, off, 32'(w));
          read_entry(s, off);
        end
      end
    end
    // A write on one slot leaves the other alone
    for (int s = 0; s < 2; s++) begin
      random_gpio(w);
      write_entry(s, int'(REG_GPIO_OUT), 32'(w));
      read_entry(1 - s, int'(REG_GPIO_OUT));
      read_entry(1 - s, int'(REG_GPIO_OUT_EN));
      // A clear on one slot keeps the flags of the other
      input_entry(1 - s, ~m_ext[1 - s]);
      write_entry(s, int'(REG_GPIO_CHANGED), 32'hffff_ffff);
      read_entry(1 - s, int'(REG_GPIO_CHANGED));
    end
  endtask

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      entry_errors++;
    end
  endtask

  task automatic check_pins(entry_t e);
    check_value("slot 0 out pins", 32'(db0_gpio_out_ext), 32'(e.exp_out0));
    check_value("slot 0 out_en pins", 32'(db0_gpio_out_en_ext), 32'(e.exp_en0));
    check_value("slot 1 out pins", 32'(db1_gpio_out_ext), 32'(e.exp_out1));
    check_value("slot 1 out_en pins", 32'(db1_gpio_out_en_ext), 32'(e.exp_en1));
  endtask

  // Strobe on a falling edge and sample the response one cycle later
  task automatic issue_request(logic wr, int slot, int offset, logic [31:0] data,
                               output logic ack, output logic [31:0] rdata);
    s_req_wr   = wr;
    s_req_rd   = ~wr;
    s_req_addr = CTRL_ADDR_W'((slot << SLOT_SEL_BIT) | offset);
    s_req_data = data;
    @(negedge ctrlport_clk);
    ack        = s_resp_ack;
    rdata      = s_resp_data;
    s_req_wr   = 1'b0;
    s_req_rd   = 1'b0;
  endtask

  task automatic apply_entry(int n);
    entry_t      e;
    logic        ack;
    logic        late_ack;
    logic [31:0] rdata;
    e = tbl[n];
    entry_errors = 0;
    if (e.op == OP_SET_IN) begin
      if (e.slot == 0)
        db0_gpio_in_ext = e.data[NUM_GPIO-1:0];
      else
        db1_gpio_in_ext = e.data[NUM_GPIO-1:0];
      // Level takes two edges and the change flag three
      repeat (4) @(negedge ctrlport_clk);
      check_pins(e);
    end else begin
      issue_request(e.op == OP_WRITE, e.slot, e.offset, e.data, ack, rdata);
      // Pins follow a write one cycle after it
      check_pins(e);
      if (e.op == OP_READ && ack)
        check_value("read data", rdata, e.exp_data);
      @(negedge ctrlport_clk);
      late_ack = s_resp_ack;
      assert (ack || late_ack) else begin
        $display("no acknowledge within two cycles at %0d ns", $time);
        entry_errors++;
      end
      if (ack || late_ack)
        assert (ack && !late_ack) else begin
          $display("Acknowledge came late or twice at %0d ns", $time);
          entry_errors++;
        end
    end
    errors += entry_errors;
    if (entry_errors != 0)
      bad_entries++;
    $display("entry %0d %s slot %0d offset %0d %s", n, e.op.name(), e.slot, e.offset,
             (entry_errors == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    rst_n           = 1'b0;
    s_req_wr        = 1'b0;
    s_req_rd        = 1'b0;
    s_req_addr      = '0;
    s_req_data      = '0;
    db0_gpio_in_ext = '0;
    db1_gpio_in_ext = '0;
    table_built     = 1'b0;
    errors          = 0;
    bad_entries     = 0;
    lfsr_state      = 32'h570f_8878;
    for (int s = 0; s < 2; s++) begin
      m_out[s]     = '0;
      m_en[s]      = '0;
      m_ext[s]     = '0;
      m_changed[s] = '0;
    end
    build_table();
    table_built = 1'b1;
    // Reset for 16 cycles and release on a falling edge
    repeat (16) @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    rst_n = 1'b1;
    foreach (tbl[n])
      apply_entry(n);
    $display("%0d entries, %0d ok, %0d with errors, %0d failed checks", tbl.size(),
             tbl.size() - bad_entries, bad_entries, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule : tb_db_gpio

`default_nettype wire

// File: db_gpio.f
db_gpio_pkg.sv
db_gpio_regs_pkg.sv
ctrlport_if.sv
db_gpio_reordering.sv
db_gpio_input_sync.sv
db_gpio_regs.sv
db_gpio_ctrlport_split.sv
db_gpio_top.sv
tb_db_gpio.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the daughterboard GPIO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_db_gpio -f db_gpio.f -o sim_tb_db_gpio

output="$(./obj_dir/sim_tb_db_gpio)"
echo "$output"

if grep -qx "Test passed" <<< "$output"; then
  exit 0
fi
exit 1
